//--- source/dma_pkg.sv
// DMA write channel shared definitions
// AXI-4 field widths, burst code and write response values
package dma_pkg;

   // Burst length field, beats minus one
   localparam int AXI_LEN_W = 8;

   localparam int AXI_SIZE_W = 3;

   localparam int AXI_BURST_W = 2;

   // Only incrementing bursts are issued and accepted
   localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR = 2'b01;

   // Write response code
   typedef logic [1:0] resp_t;

   localparam resp_t RESP_OKAY = 2'b00;

   // Subordinate error, burst out of range or unsupported
   localparam resp_t RESP_SLVERR = 2'b10;

endpackage

//--- source/dma_src_ram.sv
// Source word memory for the DMA write channel
// Fill port loads words, native read port answers one cycle later
module dma_src_ram #(
   parameter int ADDR_W      = 16,
   parameter int DATA_W      = 32,
   parameter int SRC_DEPTH_W = 6
) (
   input  logic                   clk_i,
   input  logic                   rst_i,

   // Fill write port
   input  logic                   fill_we_i,
   input  logic [SRC_DEPTH_W-1:0] fill_addr_i,
   input  logic [DATA_W-1:0]      fill_data_i,

   // Native read port
   input  logic                   iob_valid_i,
   input  logic [ADDR_W-1:0]      iob_addr_i,
   output logic [DATA_W-1:0]      iob_rdata_o,
   output logic [DATA_W/8-1:0]    iob_rstrb_o,
   output logic                   iob_ready_o
);

   localparam int BYTE_W = $clog2(DATA_W / 8);

   logic [DATA_W-1:0]      mem_q [2**SRC_DEPTH_W];
   logic [SRC_DEPTH_W-1:0] rd_idx;

   // Word part of the byte address
   assign rd_idx = iob_addr_i[BYTE_W +: SRC_DEPTH_W];

   always_ff @(posedge clk_i) begin
      if (fill_we_i) begin
         mem_q[fill_addr_i] <= fill_data_i;
      end
   end

   // Read data and strobes hold until the next request
   always_ff @(posedge clk_i) begin
      if (iob_valid_i) begin
         iob_rdata_o <= mem_q[rd_idx];
         iob_rstrb_o <= '1;
      end
   end

   // Every request is accepted and answered next cycle
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         iob_ready_o <= 1'b0;
      end else begin
         iob_ready_o <= iob_valid_i;
      end
   end

endmodule

//--- source/axi_burst_writer.sv
// AXI-4 burst writer
// Reads words over the native bus and sends them as one incrementing write burst,
// then collects the write response into the error flag
module axi_burst_writer
   import dma_pkg::*;
#(
   parameter int ADDR_W = 16,
   parameter int DATA_W = 32
) (
   input  logic                   clk_i,
   input  logic                   rst_i,

   // Control port
   input  logic                   run_i,
   input  logic [ADDR_W-1:0]      addr_i,
   input  logic [AXI_LEN_W-1:0]   length_i,
   output logic                   ready_o,
   output logic                   error_o,

   // Native read manager
   output logic                   iob_valid_o,
   output logic [ADDR_W-1:0]      iob_addr_o,
   input  logic [DATA_W-1:0]      iob_rdata_i,
   input  logic [DATA_W/8-1:0]    iob_rstrb_i,
   input  logic                   iob_ready_i,

   // AXI write address channel
   output logic [ADDR_W-1:0]      awaddr_o,
   output logic [AXI_LEN_W-1:0]   awlen_o,
   output logic [AXI_SIZE_W-1:0]  awsize_o,
   output logic [AXI_BURST_W-1:0] awburst_o,
   output logic                   awvalid_o,
   input  logic                   awready_i,

   // AXI write data channel
   output logic [DATA_W-1:0]      wdata_o,
   output logic [DATA_W/8-1:0]    wstrb_o,
   output logic                   wlast_o,
   output logic                   wvalid_o,
   input  logic                   wready_i,

   // AXI write response channel
   input  resp_t                  bresp_i,
   input  logic                   bvalid_i,
   output logic                   bready_o
);

   localparam int BYTES = DATA_W / 8;

   localparam logic [AXI_SIZE_W-1:0] AXI_SIZE = AXI_SIZE_W'($clog2(BYTES));

   // FSM states, the address handshake state also waits for run
   localparam logic [1:0] ST_ADDR_HS = 2'd0;
   localparam logic [1:0] ST_WRITE   = 2'd1;
   localparam logic [1:0] ST_RESP    = 2'd2;

   logic [1:0]           state_q;
   logic                 awvalid_q;
   logic                 hold_q;
   logic                 error_q;
   logic [AXI_LEN_W-1:0] beat_cnt_q;

   // Burst parameters and next read address
   logic [ADDR_W-1:0]    addr_q;
   logic [AXI_LEN_W-1:0] len_q;
   logic [ADDR_W-1:0]    rd_addr_q;

   logic run_accept;
   logic beat;
   logic last_beat;

   assign ready_o    = (state_q == ST_ADDR_HS);
   assign error_o    = error_q;
   assign run_accept = ready_o & run_i;

   // A word is on offer when it has just arrived or is still waiting for wready
   assign wvalid_o  = (state_q == ST_WRITE) & (iob_ready_i | hold_q);
   assign beat      = wvalid_o & wready_i;
   assign last_beat = (beat_cnt_q == len_q);
   assign wlast_o   = wvalid_o & last_beat;

   // First read goes out with run, every further read with a beat
   assign iob_valid_o = run_accept | (beat & ~last_beat);
   assign iob_addr_o  = ready_o ? addr_i : rd_addr_q;

   // Data and strobes come straight from the native read port
   assign wdata_o = iob_rdata_i;
   assign wstrb_o = iob_rstrb_i;

   assign awaddr_o  = addr_q;
   assign awlen_o   = len_q;
   assign awsize_o  = AXI_SIZE;
   assign awburst_o = AXI_BURST_INCR;
   assign awvalid_o = awvalid_q;

   // Response always accepted
   assign bready_o = 1'b1;

   always_ff @(posedge clk_i) begin
      if (run_accept) begin
         addr_q    <= addr_i;
         len_q     <= length_i;
         rd_addr_q <= addr_i + ADDR_W'(BYTES);
      end else if (beat && !last_beat) begin
         rd_addr_q <= rd_addr_q + ADDR_W'(BYTES);
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q    <= ST_ADDR_HS;
         awvalid_q  <= 1'b0;
         hold_q     <= 1'b0;
         error_q    <= 1'b0;
         beat_cnt_q <= '0;
      end else begin
         // Word stays in the RAM output register while the sink stalls
         hold_q <= wvalid_o & ~wready_i;

         if (awvalid_q && awready_i) begin
            awvalid_q <= 1'b0;
         end

         case (state_q)
            ST_ADDR_HS: begin
               if (run_i) begin
                  state_q    <= ST_WRITE;
                  awvalid_q  <= 1'b1;
                  beat_cnt_q <= '0;
               end
            end
            ST_WRITE: begin
               if (beat) begin
                  beat_cnt_q <= beat_cnt_q + 1'b1;
                  if (last_beat) begin
                     state_q <= ST_RESP;
                  end
               end
            end
            ST_RESP: begin
               // Flag follows each response, set or cleared
               if (bvalid_i) begin
                  error_q <= (bresp_i != RESP_OKAY);
                  state_q <= ST_ADDR_HS;
               end
            end
            default: begin
               state_q <= ST_ADDR_HS;
            end
         endcase
      end
   end

endmodule

//--- source/axi_mem_sink.sv
// AXI-4 write subordinate memory
// Stores one incrementing burst at a time, answers SLVERR for out-of-range bursts
module axi_mem_sink
   import dma_pkg::*;
#(
   parameter int ADDR_W       = 16,
   parameter int DATA_W       = 32,
   parameter int SINK_DEPTH_W = 6
) (
   input  logic                    clk_i,
   input  logic                    rst_i,

   // AXI write address channel
   input  logic [ADDR_W-1:0]       awaddr_i,
   input  logic [AXI_LEN_W-1:0]    awlen_i,
   input  logic [AXI_SIZE_W-1:0]   awsize_i,
   input  logic [AXI_BURST_W-1:0]  awburst_i,
   input  logic                    awvalid_i,
   output logic                    awready_o,

   // AXI write data channel
   input  logic [DATA_W-1:0]       wdata_i,
   input  logic [DATA_W/8-1:0]     wstrb_i,
   input  logic                    wlast_i,
   input  logic                    wvalid_i,
   output logic                    wready_o,

   // AXI write response channel
   output resp_t                   bresp_o,
   output logic                    bvalid_o,
   input  logic                    bready_i,

   // Read-back port
   input  logic [SINK_DEPTH_W-1:0] rd_addr_i,
   output logic [DATA_W-1:0]       rd_data_o
);

   localparam int BYTES  = DATA_W / 8;
   localparam int BYTE_W = $clog2(BYTES);
   localparam int WORD_W = ADDR_W - BYTE_W;

   localparam logic [AXI_SIZE_W-1:0] AXI_SIZE   = AXI_SIZE_W'(BYTE_W);
   localparam logic [WORD_W:0]       SINK_WORDS = 2**SINK_DEPTH_W;

   logic [DATA_W-1:0]       mem_q [2**SINK_DEPTH_W];
   logic                    active_q;
   logic                    err_q;
   logic [SINK_DEPTH_W-1:0] widx_q;
   logic [1:0]              stall_cnt_q;
   logic                    stall_q;
   logic                    bvalid_q;
   resp_t                   bresp_q;

   logic            aw_hs;
   logic            w_hs;
   logic            mem_we;
   logic            aw_reject;
   logic [WORD_W:0] aw_last_word;

   // Response phase still counts as busy
   assign awready_o = ~active_q & ~bvalid_q;
   assign wready_o  = active_q & ~stall_q;
   assign bvalid_o  = bvalid_q;
   assign bresp_o   = bresp_q;

   assign aw_hs  = awvalid_i & awready_o;
   assign w_hs   = wvalid_i & wready_o;
   assign mem_we = w_hs & ~err_q;

   // Word index of the final beat, one bit wider so it cannot wrap
   assign aw_last_word = {1'b0, awaddr_i[ADDR_W-1:BYTE_W]} + (WORD_W + 1)'(awlen_i);

   // Narrow and non-incrementing bursts are not supported either
   assign aw_reject = (aw_last_word >= SINK_WORDS) |
                      (awburst_i != AXI_BURST_INCR) |
                      (awsize_i != AXI_SIZE);

   assign rd_data_o = mem_q[rd_addr_i];

   always_ff @(posedge clk_i) begin
      if (mem_we) begin
         for (int b = 0; b < BYTES; b++) begin
            if (wstrb_i[b]) begin
               mem_q[widx_q][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         active_q    <= 1'b0;
         err_q       <= 1'b0;
         widx_q      <= '0;
         stall_cnt_q <= '0;
         stall_q     <= 1'b0;
         bvalid_q    <= 1'b0;
         bresp_q     <= RESP_OKAY;
      end else begin
         stall_q <= 1'b0;

         if (aw_hs) begin
            active_q    <= 1'b1;
            err_q       <= aw_reject;
            widx_q      <= awaddr_i[BYTE_W +: SINK_DEPTH_W];
            stall_cnt_q <= '0;
         end

         if (w_hs) begin
            widx_q      <= widx_q + 1'b1;
            stall_cnt_q <= stall_cnt_q + 1'b1;
            // One idle wready cycle after every fourth beat
            if (stall_cnt_q == 2'd3) begin
               stall_q <= 1'b1;
            end
            if (wlast_i) begin
               active_q <= 1'b0;
               bvalid_q <= 1'b1;
               bresp_q  <= err_q ? RESP_SLVERR : RESP_OKAY;
            end
         end

         if (bvalid_q && bready_i) begin
            bvalid_q <= 1'b0;
         end
      end
   end

endmodule

//--- source/dma_wr_top.sv
// DMA write channel top level
// Source RAM feeds the burst writer, which writes into the AXI sink memory
module dma_wr_top
   import dma_pkg::*;
#(
   parameter int ADDR_W       = 16,
   parameter int DATA_W       = 32,
   parameter int SRC_DEPTH_W  = 6,
   parameter int SINK_DEPTH_W = 6
) (
   input  logic                    clk_i,
   input  logic                    rst_i,

   // Source fill port
   input  logic                    fill_we_i,
   input  logic [SRC_DEPTH_W-1:0]  fill_addr_i,
   input  logic [DATA_W-1:0]       fill_data_i,

   // Transfer control
   input  logic                    run_i,
   input  logic [ADDR_W-1:0]       addr_i,
   input  logic [AXI_LEN_W-1:0]    length_i,
   output logic                    ready_o,
   output logic                    error_o,

   // Sink read-back
   input  logic [SINK_DEPTH_W-1:0] rd_addr_i,
   output logic [DATA_W-1:0]       rd_data_o
);

   // Native read bus
   logic                   iob_valid;
   logic [ADDR_W-1:0]      iob_addr;
   logic [DATA_W-1:0]      iob_rdata;
   logic [DATA_W/8-1:0]    iob_rstrb;
   logic                   iob_ready;

   // AXI write bus
   logic [ADDR_W-1:0]      awaddr;
   logic [AXI_LEN_W-1:0]   awlen;
   logic [AXI_SIZE_W-1:0]  awsize;
   logic [AXI_BURST_W-1:0] awburst;
   logic                   awvalid;
   logic                   awready;
   logic [DATA_W-1:0]      wdata;
   logic [DATA_W/8-1:0]    wstrb;
   logic                   wlast;
   logic                   wvalid;
   logic                   wready;
   resp_t                  bresp;
   logic                   bvalid;
   logic                   bready;

   dma_src_ram #(
      .ADDR_W      (ADDR_W),
      .DATA_W      (DATA_W),
      .SRC_DEPTH_W (SRC_DEPTH_W)
   ) u_src_ram (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .fill_we_i   (fill_we_i),
      .fill_addr_i (fill_addr_i),
      .fill_data_i (fill_data_i),
      .iob_valid_i (iob_valid),
      .iob_addr_i  (iob_addr),
      .iob_rdata_o (iob_rdata),
      .iob_rstrb_o (iob_rstrb),
      .iob_ready_o (iob_ready)
   );

   axi_burst_writer #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W)
   ) u_writer (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .run_i       (run_i),
      .addr_i      (addr_i),
      .length_i    (length_i),
      .ready_o     (ready_o),
      .error_o     (error_o),
      .iob_valid_o (iob_valid),
      .iob_addr_o  (iob_addr),
      .iob_rdata_i (iob_rdata),
      .iob_rstrb_i (iob_rstrb),
      .iob_ready_i (iob_ready),
      .awaddr_o    (awaddr),
      .awlen_o     (awlen),
      .awsize_o    (awsize),
      .awburst_o   (awburst),
      .awvalid_o   (awvalid),
      .awready_i   (awready),
      .wdata_o     (wdata),
      .wstrb_o     (wstrb),
      .wlast_o     (wlast),
      .wvalid_o    (wvalid),
      .wready_i    (wready),
      .bresp_i     (bresp),
      .bvalid_i    (bvalid),
      .bready_o    (bready)
   );

   axi_mem_sink #(
      .ADDR_W       (ADDR_W),
      .DATA_W       (DATA_W),
      .SINK_DEPTH_W (SINK_DEPTH_W)
   ) u_sink (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .awaddr_i  (awaddr),
      .awlen_i   (awlen),
      .awsize_i  (awsize),
      .awburst_i (awburst),
      .awvalid_i (awvalid),
      .awready_o (awready),
      .wdata_i   (wdata),
      .wstrb_i   (wstrb),
      .wlast_i   (wlast),
      .wvalid_i  (wvalid),
      .wready_o  (wready),
      .bresp_o   (bresp),
      .bvalid_o  (bvalid),
      .bready_i  (bready),
      .rd_addr_i (rd_addr_i),
      .rd_data_o (rd_data_o)
   );

endmodule

//--- verif/dma_wr_checker.sv
// Protocol assertions for the AXI burst writer
// Bound into every axi_burst_writer instance
module dma_wr_checker (
   input logic clk_i,
   input logic rst_i,
   input logic ready_i,
   input logic iob_valid_i,
   input logic awvalid_i,
   input logic awready_i,
   input logic wvalid_i,
   input logic wready_i,
   input logic wlast_i
);

   // Address leaves the bus only after the sink has taken it
   aw_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      $fell(awvalid_i) |-> $past(awready_i))
      else $error("awvalid dropped before awready");

   // Stalled beat keeps wvalid and its last flag
   wlast_with_wvalid: assert property (@(posedge clk_i) disable iff (rst_i)
      (wvalid_i && !wready_i) |=> (wvalid_i && $stable(wlast_i)))
      else $error("wvalid or wlast changed while the sink stalled");

   // Busy while any channel is active
   busy_not_ready: assert property (@(posedge clk_i) disable iff (rst_i)
      (awvalid_i || wvalid_i) |-> !ready_i)
      else $error("ready high during an active burst");

   reset_quiet: assert property (@(posedge clk_i)
      $fell(rst_i) |-> (!iob_valid_i && !awvalid_i && !wvalid_i))
      else $error("valid output high in the first cycle after reset");

endmodule

bind axi_burst_writer dma_wr_checker i_checker (
   .clk_i       (clk_i),
   .rst_i       (rst_i),
   .ready_i     (ready_o),
   .iob_valid_i (iob_valid_o),
   .awvalid_i   (awvalid_o),
   .awready_i   (awready_i),
   .wvalid_i    (wvalid_o),
   .wready_i    (wready_i),
   .wlast_i     (wlast_o)
);

//--- verif/dma_wr_tb.sv
// DMA write channel testbench
// Replays fill, run and check records from the stimulus file
module dma_wr_tb
   import dma_pkg::*;
();

   localparam int ADDR_W          = 16;
   localparam int DATA_W          = 32;
   localparam int SRC_DEPTH_W     = 6;
   localparam int SINK_DEPTH_W    = 6;
   localparam int RESET_CYCLES    = 10;
   localparam int CYCLES_PER_LINE = 40;
   localparam int NAME_W          = 8 * 16;
   localparam int LINE_W          = 8 * 128;
   localparam string STIM_FILE    = "verif/dma_wr_stimulus.txt";

   logic                    clk;
   logic                    rst;
   logic                    fill_we;
   logic [SRC_DEPTH_W-1:0]  fill_addr;
   logic [DATA_W-1:0]       fill_data;
   logic                    run;
   logic [ADDR_W-1:0]       addr;
   logic [AXI_LEN_W-1:0]    length;
   logic                    ready_o;
   logic                    error_o;
   logic [SINK_DEPTH_W-1:0] rd_addr;
   logic [DATA_W-1:0]       rd_data_o;

   int cycle_cnt   = 0;
   int cycle_limit = RESET_CYCLES;
   bit finished    = 1'b0;

   dma_wr_top #(
      .ADDR_W       (ADDR_W),
      .DATA_W       (DATA_W),
      .SRC_DEPTH_W  (SRC_DEPTH_W),
      .SINK_DEPTH_W (SINK_DEPTH_W)
   ) i_dut (
      .clk_i       (clk),
      .rst_i       (rst),
      .fill_we_i   (fill_we),
      .fill_addr_i (fill_addr),
      .fill_data_i (fill_data),
      .run_i       (run),
      .addr_i      (addr),
      .length_i    (length),
      .ready_o     (ready_o),
      .error_o     (error_o),
      .rd_addr_i   (rd_addr),
      .rd_data_o   (rd_data_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Run limit from the number of stimulus lines
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         finished = 1'b1;
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("SIMULATION FAILED");
         $fatal(1, "Run stopped on timeout");
      end
   end

   task automatic stop_with_failure(input string what);
      finished = 1'b1;
      $display("%s", what);
      $display("SIMULATION FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_resp(input logic [NAME_W-1:0] test, input resp_t expected);
      resp_t actual;
      actual = error_o ? RESP_SLVERR : RESP_OKAY;
      if (actual !== expected) begin
         stop_with_failure($sformatf("Error: test %0s expected resp %h actual resp %h",
                                     test, expected, actual));
      end
   endtask

   task automatic check_word(input logic [NAME_W-1:0] test,
                             input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
      if (actual !== expected) begin
         stop_with_failure($sformatf("Error: test %0s expected data %h actual data %h",
                                     test, expected, actual));
      end
   endtask

   task automatic fill_word(input logic [SRC_DEPTH_W-1:0] waddr,
                            input logic [DATA_W-1:0] wdata);
      @(posedge clk);
      fill_we   <= 1'b1;
      fill_addr <= waddr;
      fill_data <= wdata;
      @(posedge clk);
      fill_we <= 1'b0;
   endtask

   // One burst, then wait for ready and check the error flag
   task automatic run_transfer(input logic [NAME_W-1:0] test,
                               input logic [ADDR_W-1:0] baddr,
                               input logic [AXI_LEN_W-1:0] len,
                               input resp_t expected);
      int gap;
      gap = int'($urandom % 4);
      repeat (gap) @(posedge clk);
      @(negedge clk);
      if (!ready_o) begin
         stop_with_failure("ready_o was low when a new run was due");
      end
      @(posedge clk);
      run    <= 1'b1;
      addr   <= baddr;
      length <= len;
      @(posedge clk);
      run <= 1'b0;
      @(negedge clk);
      while (!ready_o) begin
         @(negedge clk);
      end
      check_resp(test, expected);
   endtask

   task automatic check_sink(input logic [NAME_W-1:0] test,
                             input logic [SINK_DEPTH_W-1:0] waddr,
                             input logic [DATA_W-1:0] expected);
      @(posedge clk);
      rd_addr <= waddr;
      @(negedge clk);
      check_word(test, expected, rd_data_o);
   endtask

   initial begin
      int                   fd;
      int                   code;
      int                   lines;
      logic [7:0]           kind;
      logic [NAME_W-1:0]    name;
      logic [ADDR_W-1:0]    a;
      logic [DATA_W-1:0]    d;
      logic [AXI_LEN_W-1:0] len;
      resp_t                resp;
      logic [LINE_W-1:0]    text;

      void'($urandom(29876));
      rst       = 1'b1;
      fill_we   = 1'b0;
      fill_addr = '0;
      fill_data = '0;
      run       = 1'b0;
      addr      = '0;
      length    = '0;
      rd_addr   = '0;

      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         stop_with_failure("Could not open the stimulus file");
      end
      lines = 0;
      while ($fgets(text, fd) != 0) begin
         lines++;
      end
      $fclose(fd);
      cycle_limit = RESET_CYCLES + CYCLES_PER_LINE * lines;

      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;

      fd = $fopen(STIM_FILE, "r");
      while (!$feof(fd)) begin
         code = $fscanf(fd, " %c", kind);
         if (code != 1) begin
            break;
         end
         case (kind)
            "#": code = $fgets(text, fd);
            "F": begin
               if ($fscanf(fd, "%h %h", a, d) != 2) begin
                  stop_with_failure("Bad fill record in the stimulus file");
               end
               fill_word(SRC_DEPTH_W'(a), d);
            end
            "R": begin
               if ($fscanf(fd, "%s %h %h %h", name, a, len, resp) != 4) begin
                  stop_with_failure("Bad run record in the stimulus file");
               end
               run_transfer(name, a, len, resp);
            end
            "C": begin
               if ($fscanf(fd, "%s %h %h", name, a, d) != 3) begin
                  stop_with_failure("Bad check record in the stimulus file");
               end
               check_sink(name, SINK_DEPTH_W'(a), d);
            end
            default: stop_with_failure("Unknown record kind in the stimulus file");
         endcase
      end
      $fclose(fd);

      finished = 1'b1;
      $display("SIMULATION PASSED");
      $finish;
   end

   // Catches a run that was stopped from elsewhere, such as by an assertion
   final begin
      if (!finished) begin
         $display("SIMULATION FAILED");
      end
   end

endmodule

//--- files.f
source/dma_pkg.sv
source/dma_src_ram.sv
source/axi_burst_writer.sv
source/axi_mem_sink.sv
source/dma_wr_top.sv
verif/dma_wr_checker.sv
verif/dma_wr_tb.sv

//--- Makefile
VERILATOR = verilator
SIM_FLAGS = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP       = dma_wr_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/dma_wr_stimulus.txt
# F src_word data | R name byte_addr length resp | C name sink_word data
# All numbers hex, resp 0 is OKAY and 2 is SLVERR
F 04 a5a50004
R single 0010 00 0
C single 04 a5a50004
F 08 10000008
F 09 10000009
F 0a 1000000a
F 0b 1000000b
F 0c 1000000c
F 0d 1000000d
F 0e 1000000e
F 0f 1000000f
F 10 10000010
F 11 10000011
F 12 10000012
F 13 10000013
F 14 10000014
F 15 10000015
F 16 10000016
F 17 10000017
R burst16 0020 0f 0
C burst16 08 10000008
C burst16 0b 1000000b
C burst16 0c 1000000c
C burst16 0f 1000000f
C burst16 10 10000010
C burst16 13 10000013
C burst16 14 10000014
C burst16 17 10000017
F 3c 3c3c0000
F 3d 3d3d0001
F 3e 3e3e0002
F 3f 3f3f0003
R edge_pre 00f0 03 0
C edge_pre 3f 3f3f0003
F 3c badd003c
F 3f badd003f
R overrun 00f0 07 2
C overrun 3c 3c3c0000
C overrun 3d 3d3d0001
C overrun 3f 3f3f0003
F 10 c0de0010
F 11 c0de0011
R recover 0040 01 0
C recover 10 c0de0010
C recover 11 c0de0011
F 18 b2b00018
F 19 b2b00019
F 1a b2b0001a
F 1b b2b0001b
F 1c b2b0001c
R b2b_a 0060 01 0
R b2b_b 0068 00 0
R b2b_c 006c 01 0
C b2b_a 18 b2b00018
C b2b_a 19 b2b00019
C b2b_b 1a b2b0001a
C b2b_c 1b b2b0001b
C b2b_c 1c b2b0001c
